// ==== build.f ====
verilog/mem_pkg.sv
verilog/req_queue.sv
verilog/addr_router.sv
verilog/bram_ctrl.sv
verilog/bram_array.sv
verilog/mem_subsys_top.sv
tb/mem_subsys_sva.sv
tb/mem_checker.sv
tb/tb_top.sv

// ==== tb/mem_checker.sv ====
// response checker: line model and in-order expected responses built from the DUT ports
`timescale 1ns/100ps

module mem_checker (
   input logic           ram_clk,
   input logic           arst_n,
   input logic           req_valid,
   input logic           req_write,
   input mem_pkg::id_t   req_id,
   input mem_pkg::addr_t req_addr,
   input mem_pkg::data_t req_wdata,
   input mem_pkg::strb_t req_strb,
   input logic           req_credit,
   input logic           resp_valid,
   input mem_pkg::id_t   resp_id,
   input mem_pkg::resp_e resp_code,
   input mem_pkg::data_t resp_rdata
);

   localparam int LATENCY = 3;   // request sample to resp_valid, empty queue
   localparam int WINDOW  = 2 ** mem_pkg::BRAM_ADDR_WIDTH;

   mem_pkg::data_t model [mem_pkg::BRAM_LINES];
   mem_pkg::id_t   exp_id   [$];
   mem_pkg::resp_e exp_code [$];
   mem_pkg::data_t exp_data [$];
   int             exp_cyc  [$];

   int err_count    = 0;
   int req_count    = 0;
   int credit_count = 0;
   int pending      = 0;
   int cyc          = 0;
   int qcnt         = 0;   // requests sitting in the DUT queue

   task automatic value_error(input string msg);
      err_count++;
      $display("error %0t: %s", $time, msg);
   endtask

   task automatic protocol_error(input string msg);
      err_count++;
      $display("%s", msg);
   endtask

   task automatic record_req();
      mem_pkg::line_addr_t line;
      int                  ahead;
      line  = mem_pkg::line_addr_t'(req_addr >> mem_pkg::LINE_OFFSET);
      ahead = (qcnt > 0) ? qcnt - 1 : 0;   // head pops at this edge
      exp_id.push_back(req_id);
      // seen half a cycle before its sample edge, response half a cycle after
      exp_cyc.push_back(cyc + 1 + LATENCY + ahead);
      if (int'(req_addr) >= WINDOW) begin
         exp_code.push_back(mem_pkg::resp_decerr);
         exp_data.push_back('0);
      end else if (req_write) begin
         for (int i = 0; i < mem_pkg::STRB_WIDTH; i++)
            if (req_strb[i])
               model[line][i*8 +: 8] = req_wdata[i*8 +: 8];
         exp_code.push_back(mem_pkg::resp_okay);
         exp_data.push_back('0);
      end else begin
         exp_code.push_back(mem_pkg::resp_okay);
         exp_data.push_back(model[line]);
      end
      req_count++;
      pending++;
   endtask

   task automatic check_resp();
      if (pending == 0) begin
         protocol_error("response arrived with no request outstanding");
      end else begin
         if (resp_id !== exp_id[0])
            value_error($sformatf("resp_id %h, expected %h", resp_id, exp_id[0]));
         if (resp_code !== exp_code[0])
            value_error($sformatf("id %h resp_code %0d, expected %0d",
                                  exp_id[0], resp_code, exp_code[0]));
         if (resp_rdata !== exp_data[0])
            value_error($sformatf("id %h resp_rdata %h, expected %h",
                                  exp_id[0], resp_rdata, exp_data[0]));
         if (cyc != exp_cyc[0])
            value_error($sformatf("id %h response in cycle %0d, expected %0d",
                                  exp_id[0], cyc, exp_cyc[0]));
         void'(exp_id.pop_front());
         void'(exp_code.pop_front());
         void'(exp_data.pop_front());
         void'(exp_cyc.pop_front());
         pending--;
      end
   endtask

   task automatic check_credit_total();
      if (credit_count != req_count)
         value_error($sformatf("%0d credit pulses for %0d requests", credit_count, req_count));
   endtask

   // mid-cycle sampling, inputs and outputs are both settled here
   always @(negedge ram_clk) begin : sample
      logic pop;
      cyc++;
      pop = (qcnt != 0);
      if (req_credit !== pop)
         value_error($sformatf("req_credit %b with %0d requests queued", req_credit, qcnt));
      if (req_credit === 1'b1)
         credit_count++;
      if (resp_valid === 1'b1)
         check_resp();
      else if (resp_valid !== 1'b0)
         protocol_error("resp_valid is unknown");
      if (arst_n === 1'b1 && req_valid === 1'b1) begin
         record_req();
         qcnt = qcnt + 1;
      end
      qcnt = qcnt - int'(pop);
   end

endmodule

// ==== tb/mem_subsys_sva.sv ====
// port assertions for the memory subsystem: credit bound, quiet reset, decerr data
`timescale 1ns/100ps

module mem_subsys_sva (
   input logic           ram_clk,
   input logic           arst_n,
   input logic           req_valid,
   input logic           req_credit,
   input logic           resp_valid,
   input mem_pkg::resp_e resp_code,
   input mem_pkg::data_t resp_rdata
);

   int outstanding;        // requests sent and not yet credited
   int assert_fails = 0;

   always_ff @(posedge ram_clk or negedge arst_n) begin
      if (!arst_n)
         outstanding <= 0;
      else
         outstanding <= outstanding + int'(req_valid) - int'(req_credit);
   end

   credit_bound: assert property (@(posedge ram_clk) disable iff (!arst_n)
      outstanding + int'(req_valid) - int'(req_credit) <= mem_pkg::REQ_DEPTH)
      else begin
         assert_fails++;
         $error("master sent more requests than it held credits for");
      end

   quiet_in_reset: assert property (@(posedge ram_clk) !arst_n |-> !resp_valid)
      else begin
         assert_fails++;
         $error("resp_valid high during reset");
      end

   decerr_no_data: assert property (@(posedge ram_clk) disable iff (!arst_n)
      (resp_valid && resp_code == mem_pkg::resp_decerr) |-> resp_rdata == '0)
      else begin
         assert_fails++;
         $error("decode error response carries data");
      end

endmodule

// ==== tb/tb_top.sv ====
// testbench top: clock, reset, LFSR stimulus with credit tracking, tests and watchdog
`timescale 1ns/100ps

module tb_top;

   localparam int TOTAL_REQS      = 160;
   localparam int WATCHDOG_CYCLES = (TOTAL_REQS + 10) * 6;

   logic           ram_clk = 1'b0;
   logic           arst_n;
   logic           req_valid;
   logic           req_write;
   mem_pkg::id_t   req_id;
   mem_pkg::addr_t req_addr;
   mem_pkg::data_t req_wdata;
   mem_pkg::strb_t req_strb;
   logic           req_credit;
   logic           resp_valid;
   mem_pkg::id_t   resp_id;
   mem_pkg::resp_e resp_code;
   mem_pkg::data_t resp_rdata;

   logic [31:0] lfsr      = 32'hf494;
   int          credits   = 0;
   int          tests_run = 0;
   int          test_err0 = 0;
   int          test_req0 = 0;

   always #5 ram_clk = ~ram_clk;

   mem_subsys_top mem_subsys_top_inst (.*);
   mem_checker mem_checker_inst (.*);
   bind mem_subsys_top mem_subsys_sva mem_subsys_sva_inst (.*);

   always @(negedge ram_clk)
      if (req_credit === 1'b1)
         credits++;   // usable from the next drive

   function automatic logic [127:0] rand_bits(input int n);
      logic [127:0] v;
      logic         fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
         lfsr = {lfsr[30:0], fb};
         v    = {v[126:0], fb};
      end
      return v;
   endfunction

   // one of 16 lines spread over the window, random byte offset
   function automatic mem_pkg::addr_t window_addr(input logic [3:0] sel);
      logic [3:0] offs;
      offs = 4'(rand_bits(4));
      return {2'b00, sel, 6'd5, offs};
   endfunction

   // above the window, low bits alias one of the 16 test lines
   function automatic mem_pkg::addr_t outside_addr(input logic [3:0] sel);
      logic [1:0] hi;
      logic [3:0] offs;
      hi   = 2'(rand_bits(2));
      offs = 4'(rand_bits(4));
      if (hi == 2'b00)
         hi = 2'b11;
      return {hi, sel, 6'd5, offs};
   endfunction

   task automatic tick();
      @(posedge ram_clk);
      #1;
   endtask

   task automatic send_req(input logic wr, input mem_pkg::id_t id, input mem_pkg::addr_t addr,
                           input mem_pkg::data_t wdata, input mem_pkg::strb_t strb);
      while (credits == 0)
         tick();
      req_valid = 1'b1;
      req_write = wr;
      req_id    = id;
      req_addr  = addr;
      req_wdata = wdata;
      req_strb  = strb;
      credits--;
      tick();
      req_valid = 1'b0;
   endtask

   task automatic drain();
      while (mem_checker_inst.pending != 0)
         tick();
      repeat (2) tick();
   endtask

   task automatic start_test();
      test_err0 = mem_checker_inst.err_count;
      test_req0 = mem_checker_inst.req_count;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("test %0d %s: %0d requests, %0d errors", tests_run, name,
               mem_checker_inst.req_count - test_req0, mem_checker_inst.err_count - test_err0);
   endtask

   initial begin
      logic       wr;
      logic [3:0] sel;
      arst_n    = 1'b1;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_id    = '0;
      req_addr  = '0;
      req_wdata = '0;
      req_strb  = '0;

      start_test();
      #1 arst_n = 1'b0;
      repeat (8) @(posedge ram_clk);
      #1 arst_n = 1'b1;
      credits = mem_pkg::REQ_DEPTH;
      repeat (4) tick();
      end_test("reset and idle");

      start_test();
      for (int s = 0; s < 16; s++)
         send_req(1'b1, 4'(rand_bits(4)), window_addr(4'(s)), rand_bits(128), '1);
      for (int s = 0; s < 16; s++)
         send_req(1'b0, 4'(rand_bits(4)), window_addr(4'(s)), '0, '0);
      drain();
      end_test("full-mask writes and reads");

      start_test();
      for (int i = 0; i < 64; i++) begin
         wr  = 1'(rand_bits(1));
         sel = 4'(rand_bits(4));
         send_req(wr, 4'(rand_bits(4)), window_addr(sel), rand_bits(128), 16'(rand_bits(16)));
      end
      drain();
      end_test("random partial writes and reads");

      start_test();
      for (int i = 0; i < 16; i++) begin
         wr = 1'(rand_bits(1));
         send_req(wr, 4'(rand_bits(4)), outside_addr(4'(i)), rand_bits(128), '1);
      end
      for (int s = 0; s < 16; s++)
         send_req(1'b0, 4'(rand_bits(4)), window_addr(4'(s)), '0, '0);
      drain();
      end_test("out-of-window decode errors");

      start_test();
      for (int i = 0; i < 32; i++) begin
         wr  = 1'(rand_bits(1));
         sel = 4'(rand_bits(4));
         send_req(wr, mem_pkg::id_t'(i), window_addr(sel), rand_bits(128), 16'(rand_bits(16)));
      end
      drain();
      mem_checker_inst.check_credit_total();
      end_test("full credit rate ordering");

      $display("%0d tests, %0d requests, %0d credits, %0d errors, %0d assertion failures",
               tests_run, mem_checker_inst.req_count, mem_checker_inst.credit_count,
               mem_checker_inst.err_count, mem_subsys_top_inst.mem_subsys_sva_inst.assert_fails);
      if (mem_checker_inst.err_count == 0 &&
          mem_subsys_top_inst.mem_subsys_sva_inst.assert_fails == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge ram_clk);
      $display("run timed out after %0d cycles with %0d responses outstanding",
               WATCHDOG_CYCLES, mem_checker_inst.pending);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== verilog/addr_router.sv ====
// address router: RAM window decode, decode-error path and ordered response merge
`timescale 1ns/100ps

module addr_router (
   input  logic                ram_clk,
   input  logic                arst_n,

   // popped request
   input  logic                q_valid,
   input  logic                q_write,
   input  mem_pkg::id_t        q_id,
   input  mem_pkg::addr_t      q_addr,
   input  mem_pkg::data_t      q_wdata,
   input  mem_pkg::strb_t      q_strb,

   // to BRAM controller
   output logic                b_valid,
   output logic                b_write,
   output mem_pkg::id_t        b_id,
   output mem_pkg::line_addr_t b_line,
   output mem_pkg::data_t      b_wdata,
   output mem_pkg::strb_t      b_strb,
   input  logic                b_resp_valid,
   input  mem_pkg::id_t        b_resp_id,
   input  mem_pkg::data_t      b_resp_rdata,

   // merged response
   output logic                resp_valid,
   output mem_pkg::id_t        resp_id,
   output mem_pkg::resp_e      resp_code,
   output mem_pkg::data_t      resp_rdata
);

   logic         in_win;
   logic         err_v1;
   logic         err_v2;
   mem_pkg::id_t err_id1;
   mem_pkg::id_t err_id2;

   // anything above the RAM window is a decode error
   assign in_win = (q_addr[mem_pkg::ADDR_WIDTH-1:mem_pkg::BRAM_ADDR_WIDTH] == '0);

   assign b_valid = q_valid && in_win;
   assign b_write = q_write;
   assign b_id    = q_id;
   assign b_line  = q_addr[mem_pkg::BRAM_ADDR_WIDTH-1:mem_pkg::LINE_OFFSET];
   assign b_wdata = q_wdata;
   assign b_strb  = q_strb;

   // error path matches the two BRAM controller stages, keeps order
   always_ff @(posedge ram_clk or negedge arst_n) begin
      if (!arst_n) begin
         err_v1 <= 1'b0;
         err_v2 <= 1'b0;
      end else begin
         err_v1 <= q_valid && !in_win;
         err_v2 <= err_v1;
      end
   end

   always_ff @(posedge ram_clk) begin
      err_id1 <= q_id;
      err_id2 <= err_id1;
   end

   // at most one of the two paths is valid per cycle
   always_ff @(posedge ram_clk or negedge arst_n) begin
      if (!arst_n) begin
         resp_valid <= 1'b0;
         resp_code  <= mem_pkg::resp_okay;
      end else begin
         resp_valid <= b_resp_valid || err_v2;
         resp_code  <= err_v2 ? mem_pkg::resp_decerr : mem_pkg::resp_okay;
      end
   end

   always_ff @(posedge ram_clk) begin
      resp_id    <= err_v2 ? err_id2 : b_resp_id;
      resp_rdata <= err_v2 ? '0 : b_resp_rdata;   // decerr carries no data
   end

endmodule

// ==== verilog/bram_array.sv ====
// block RAM: byte-writable line memory, read through a registered line index
`timescale 1ns/100ps

module bram_array (
   input  logic                ram_clk,
   input  logic                ram_en,
   input  mem_pkg::strb_t      ram_we,
   input  mem_pkg::line_addr_t ram_line,
   input  mem_pkg::data_t      ram_wrdata,
   output mem_pkg::data_t      ram_rddata
);

   mem_pkg::data_t      mem [mem_pkg::BRAM_LINES];
   mem_pkg::line_addr_t line_q;

   always_ff @(posedge ram_clk) begin
      if (ram_en) begin
         line_q <= ram_line;
         foreach (ram_we[i]) begin
            if (ram_we[i])
               mem[ram_line][i*8 +: 8] <= ram_wrdata[i*8 +: 8];
         end
      end
   end

   // read-first is not needed, the line is read a cycle after the write edge
   assign ram_rddata = mem[line_q];

endmodule

// ==== verilog/bram_ctrl.sv ====
// BRAM controller: request to RAM strobes, two-stage response with read data
`timescale 1ns/100ps

module bram_ctrl (
   input  logic                ram_clk,
   input  logic                arst_n,

   input  logic                b_valid,
   input  logic                b_write,
   input  mem_pkg::id_t        b_id,
   input  mem_pkg::line_addr_t b_line,
   input  mem_pkg::data_t      b_wdata,
   input  mem_pkg::strb_t      b_strb,

   output logic                b_resp_valid,
   output mem_pkg::id_t        b_resp_id,
   output mem_pkg::data_t      b_resp_rdata,

   // RAM port
   output logic                ram_en,
   output mem_pkg::strb_t      ram_we,
   output mem_pkg::line_addr_t ram_line,
   output mem_pkg::data_t      ram_wrdata,
   input  mem_pkg::data_t      ram_rddata
);

   logic         v1;
   logic         wr1;
   mem_pkg::id_t id1;

   assign ram_en     = b_valid;
   assign ram_we     = (b_valid && b_write) ? b_strb : '0;  // reads write nothing
   assign ram_line   = b_line;
   assign ram_wrdata = b_wdata;

   always_ff @(posedge ram_clk or negedge arst_n) begin
      if (!arst_n) begin
         v1           <= 1'b0;
         b_resp_valid <= 1'b0;
      end else begin
         v1           <= b_valid;
         b_resp_valid <= v1;
      end
   end

   // stage 2 samples the line read at the stage 1 edge
   always_ff @(posedge ram_clk) begin
      wr1          <= b_write;
      id1          <= b_id;
      b_resp_id    <= id1;
      b_resp_rdata <= wr1 ? '0 : ram_rddata;
   end

endmodule

// ==== verilog/mem_pkg.sv ====
// memory path package: bus widths, RAM geometry, address map and response codes
package mem_pkg;

   // request channel
   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 128;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;
   localparam int ID_WIDTH   = 4;

   // RAM window, 16 KB at the bottom of the address map
   localparam int BRAM_ADDR_WIDTH = 14;
   localparam int LINE_OFFSET     = $clog2(STRB_WIDTH); // byte within a line
   localparam int BRAM_LINES      = (2 ** BRAM_ADDR_WIDTH) * 8 / DATA_WIDTH;

   // also the master's credit count after reset
   localparam int REQ_DEPTH = 4;

   typedef logic [ADDR_WIDTH-1:0]                  addr_t;
   typedef logic [BRAM_ADDR_WIDTH-LINE_OFFSET-1:0] line_addr_t;
   typedef logic [DATA_WIDTH-1:0]                  data_t;
   typedef logic [STRB_WIDTH-1:0]                  strb_t;
   typedef logic [ID_WIDTH-1:0]                    id_t;

   // same encodings as the AXI resp field
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_decerr = 2'b11
   } resp_e;

endpackage

// ==== verilog/mem_subsys_top.sv ====
// memory subsystem top: request queue, address router, BRAM controller and RAM
`timescale 1ns/100ps

module mem_subsys_top (
   input  logic            ram_clk,
   input  logic            arst_n,

   // request channel from the master
   input  logic            req_valid,
   input  logic            req_write,
   input  mem_pkg::id_t    req_id,
   input  mem_pkg::addr_t  req_addr,
   input  mem_pkg::data_t  req_wdata,
   input  mem_pkg::strb_t  req_strb,
   output logic            req_credit,

   // response channel, no back-pressure
   output logic            resp_valid,
   output mem_pkg::id_t    resp_id,
   output mem_pkg::resp_e  resp_code,
   output mem_pkg::data_t  resp_rdata
);

   // queue to router
   logic                q_valid;
   logic                q_write;
   mem_pkg::id_t        q_id;
   mem_pkg::addr_t      q_addr;
   mem_pkg::data_t      q_wdata;
   mem_pkg::strb_t      q_strb;

   // router to BRAM controller
   logic                b_valid;
   logic                b_write;
   mem_pkg::id_t        b_id;
   mem_pkg::line_addr_t b_line;
   mem_pkg::data_t      b_wdata;
   mem_pkg::strb_t      b_strb;
   logic                b_resp_valid;
   mem_pkg::id_t        b_resp_id;
   mem_pkg::data_t      b_resp_rdata;

   // RAM port
   logic                ram_en;
   mem_pkg::strb_t      ram_we;
   mem_pkg::line_addr_t ram_line;
   mem_pkg::data_t      ram_wrdata;
   mem_pkg::data_t      ram_rddata;

   req_queue #(
      .REQ_DEPTH  ( mem_pkg::REQ_DEPTH )
   ) req_queue_inst (
      .ram_clk    ( ram_clk    ),
      .arst_n     ( arst_n     ),
      .req_valid  ( req_valid  ),
      .req_write  ( req_write  ),
      .req_id     ( req_id     ),
      .req_addr   ( req_addr   ),
      .req_wdata  ( req_wdata  ),
      .req_strb   ( req_strb   ),
      .req_credit ( req_credit ),
      .q_valid    ( q_valid    ),
      .q_write    ( q_write    ),
      .q_id       ( q_id       ),
      .q_addr     ( q_addr     ),
      .q_wdata    ( q_wdata    ),
      .q_strb     ( q_strb     )
   );

   addr_router addr_router_inst (
      .ram_clk      ( ram_clk      ),
      .arst_n       ( arst_n       ),
      .q_valid      ( q_valid      ),
      .q_write      ( q_write      ),
      .q_id         ( q_id         ),
      .q_addr       ( q_addr       ),
      .q_wdata      ( q_wdata      ),
      .q_strb       ( q_strb       ),
      .b_valid      ( b_valid      ),
      .b_write      ( b_write      ),
      .b_id         ( b_id         ),
      .b_line       ( b_line       ),
      .b_wdata      ( b_wdata      ),
      .b_strb       ( b_strb       ),
      .b_resp_valid ( b_resp_valid ),
      .b_resp_id    ( b_resp_id    ),
      .b_resp_rdata ( b_resp_rdata ),
      .resp_valid   ( resp_valid   ),
      .resp_id      ( resp_id      ),
      .resp_code    ( resp_code    ),
      .resp_rdata   ( resp_rdata   )
   );

   bram_ctrl bram_ctrl_inst (
      .ram_clk      ( ram_clk      ),
      .arst_n       ( arst_n       ),
      .b_valid      ( b_valid      ),
      .b_write      ( b_write      ),
      .b_id         ( b_id         ),
      .b_line       ( b_line       ),
      .b_wdata      ( b_wdata      ),
      .b_strb       ( b_strb       ),
      .b_resp_valid ( b_resp_valid ),
      .b_resp_id    ( b_resp_id    ),
      .b_resp_rdata ( b_resp_rdata ),
      .ram_en       ( ram_en       ),
      .ram_we       ( ram_we       ),
      .ram_line     ( ram_line     ),
      .ram_wrdata   ( ram_wrdata   ),
      .ram_rddata   ( ram_rddata   )
   );

   bram_array bram_array_inst (
      .ram_clk    ( ram_clk    ),
      .ram_en     ( ram_en     ),
      .ram_we     ( ram_we     ),
      .ram_line   ( ram_line   ),
      .ram_wrdata ( ram_wrdata ),
      .ram_rddata ( ram_rddata )
   );

endmodule

// ==== verilog/req_queue.sv ====
// request queue: circular buffer of requests, one credit returned per pop
`timescale 1ns/100ps

module req_queue #(
   parameter int REQ_DEPTH = mem_pkg::REQ_DEPTH
) (
   input  logic            ram_clk,
   input  logic            arst_n,

   input  logic            req_valid,
   input  logic            req_write,
   input  mem_pkg::id_t    req_id,
   input  mem_pkg::addr_t  req_addr,
   input  mem_pkg::data_t  req_wdata,
   input  mem_pkg::strb_t  req_strb,
   output logic            req_credit,

   output logic            q_valid,
   output logic            q_write,
   output mem_pkg::id_t    q_id,
   output mem_pkg::addr_t  q_addr,
   output mem_pkg::data_t  q_wdata,
   output mem_pkg::strb_t  q_strb
);

   localparam int PTR_WIDTH = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int CNT_WIDTH = $clog2(REQ_DEPTH + 1);

   logic           write_mem [REQ_DEPTH];
   mem_pkg::id_t   id_mem    [REQ_DEPTH];
   mem_pkg::addr_t addr_mem  [REQ_DEPTH];
   mem_pkg::data_t wdata_mem [REQ_DEPTH];
   mem_pkg::strb_t strb_mem  [REQ_DEPTH];

   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] count;
   logic                 pop;

   assign pop        = (count != '0);   // router never stalls
   assign req_credit = pop;
   assign q_valid    = pop;

   always_ff @(posedge ram_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (req_valid)
            wr_ptr <= (wr_ptr == PTR_WIDTH'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_WIDTH'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CNT_WIDTH'(req_valid) - CNT_WIDTH'(pop);
      end
   end

   // payload storage
   always_ff @(posedge ram_clk) begin
      if (req_valid) begin
         write_mem[wr_ptr] <= req_write;
         id_mem[wr_ptr]    <= req_id;
         addr_mem[wr_ptr]  <= req_addr;
         wdata_mem[wr_ptr] <= req_wdata;
         strb_mem[wr_ptr]  <= req_strb;
      end
   end

   assign q_write = write_mem[rd_ptr];
   assign q_id    = id_mem[rd_ptr];
   assign q_addr  = addr_mem[rd_ptr];
   assign q_wdata = wdata_mem[rd_ptr];
   assign q_strb  = strb_mem[rd_ptr];

endmodule
